// File: logic/rs_consts.svh
`ifndef RS_CONSTS_SVH
`define RS_CONSTS_SVH

// reservation station entries
`define RS_DEPTH 8

// reorder buffer entries, one tag each
`define ROB_DEPTH 16

// width of a reorder buffer tag
`define TAG_W 4

// data path width
`define XLEN 32

// free count has to reach RS_DEPTH itself
`define CNT_W 4

`endif

// File: logic/rs_pkg.sv
`default_nettype none

`include "rs_consts.svh"

package rs_pkg;

	// reorder buffer tag
	typedef logic [`TAG_W-1:0] rob_tag_t;
	// register value or immediate
	typedef logic [`XLEN-1:0] word_t;
	// number of free station entries
	typedef logic [`CNT_W-1:0] rs_count_t;

	// rv32i major opcodes handled by this slice
	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} rv32_opcode_e;

	// funct3 slots 010 and 011 carry sra and sub, slt and sltu go to the comparator
	typedef enum logic [2:0] {
		alu_add = 3'b000,
		alu_sll = 3'b001,
		alu_sra = 3'b010,
		alu_sub = 3'b011,
		alu_xor = 3'b100,
		alu_srl = 3'b101,
		alu_or  = 3'b110,
		alu_and = 3'b111
	} alu_op_e;

	// same encoding as the branch funct3
	typedef enum logic [2:0] {
		cmp_beq  = 3'b000,
		cmp_bne  = 3'b001,
		cmp_blt  = 3'b100,
		cmp_bge  = 3'b101,
		cmp_bltu = 3'b110,
		cmp_bgeu = 3'b111
	} cmp_op_e;

	// true for front <= tag < flush_tag, counted around the rob ring
	// front equal to flush_tag gives an empty window, so everything is flushed
	function automatic logic tag_in_window(rob_tag_t tag, rob_tag_t front, rob_tag_t flush_tag);
		int dist_tag;
		int dist_flush;
		dist_tag = (int'(tag) + `ROB_DEPTH - int'(front)) % `ROB_DEPTH;
		dist_flush = (int'(flush_tag) + `ROB_DEPTH - int'(front)) % `ROB_DEPTH;
		return dist_tag < dist_flush;
	endfunction

endpackage

`default_nettype wire

// File: logic/rs_if.sv
`timescale 1ns/1ns
`default_nettype none

// one renamed instruction, ready to be written into a station entry
// a busy operand carries the tag it waits for in its low bits
interface rs_issue_if
	import rs_pkg::*;
();
	logic valid;
	rob_tag_t tag;
	alu_op_e alu_op;
	cmp_op_e cmp_op;
	logic use_cmp;
	word_t a;
	word_t b;
	logic a_busy;
	logic b_busy;

	modport src (output valid, tag, alu_op, cmp_op, use_cmp, a, b, a_busy, b_busy);
	modport dst (input valid, tag, alu_op, cmp_op, use_cmp, a, b, a_busy, b_busy);
endinterface

// operation leaving the station, execute unit takes one per cycle
interface rs_dispatch_if
	import rs_pkg::*;
();
	logic valid;
	rob_tag_t tag;
	alu_op_e alu_op;
	cmp_op_e cmp_op;
	logic use_cmp;
	word_t a;
	word_t b;

	modport src (output valid, tag, alu_op, cmp_op, use_cmp, a, b);
	modport dst (input valid, tag, alu_op, cmp_op, use_cmp, a, b);
endinterface

`default_nettype wire

// File: logic/issue_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "rs_consts.svh"

module issue_decode
	import rs_pkg::*;
(
	input logic issue_valid,
	input rob_tag_t tag,
	input rv32_opcode_e opcode,
	input logic [2:0] funct3,
	input logic funct7_5,
	input word_t pc,
	input word_t imm,
	input word_t rs1_val,
	input word_t rs2_val,
	input logic rs1_busy,
	input logic rs2_busy,
	input logic result_valid,
	input logic rob_valid,
	input rob_tag_t result_tag,
	input rob_tag_t rob_tag,
	input word_t result_value,
	input word_t rob_value,
	rs_issue_if.src issue
);
	// operands before the bypass
	word_t a_raw;
	word_t b_raw;
	logic a_busy_raw;
	logic b_busy_raw;

	always_comb begin
		// register-register form unless the opcode says otherwise
		a_raw = rs1_val;
		b_raw = rs2_val;
		a_busy_raw = rs1_busy;
		b_busy_raw = rs2_busy;
		issue.alu_op = alu_add;
		issue.cmp_op = cmp_beq;
		issue.use_cmp = 1'b0;
		case (opcode)
			op_lui: begin
				// imm + 0
				a_raw = imm;
				b_raw = '0;
				a_busy_raw = 1'b0;
				b_busy_raw = 1'b0;
			end
			op_auipc, op_jal: begin
				a_raw = pc;
				b_raw = imm;
				a_busy_raw = 1'b0;
				b_busy_raw = 1'b0;
			end
			op_jalr: begin
				b_raw = imm;
				b_busy_raw = 1'b0;
			end
			op_br: begin
				issue.use_cmp = 1'b1;
				issue.cmp_op = cmp_op_e'(funct3);
			end
			op_imm, op_reg: begin
				if (opcode == op_imm) begin
					b_raw = imm;
					b_busy_raw = 1'b0;
				end
				case (funct3)
					// sub only exists in the register form
					3'b000: issue.alu_op = (opcode == op_reg && funct7_5) ? alu_sub : alu_add;
					3'b001: issue.alu_op = alu_sll;
					3'b010: begin
						issue.use_cmp = 1'b1;
						issue.cmp_op = cmp_blt;
					end
					3'b011: begin
						issue.use_cmp = 1'b1;
						issue.cmp_op = cmp_bltu;
					end
					3'b100: issue.alu_op = alu_xor;
					3'b101: issue.alu_op = funct7_5 ? alu_sra : alu_srl;
					3'b110: issue.alu_op = alu_or;
					default: issue.alu_op = alu_and;
				endcase
			end
			default: begin
				a_busy_raw = 1'b0;
				b_busy_raw = 1'b0;
			end
		endcase
	end

	// a tag broadcast this cycle would be missed by the station, take it here
	always_comb begin
		issue.a = a_raw;
		issue.a_busy = a_busy_raw;
		issue.b = b_raw;
		issue.b_busy = b_busy_raw;
		if (a_busy_raw && result_valid && result_tag == a_raw[`TAG_W-1:0]) begin
			issue.a = result_value;
			issue.a_busy = 1'b0;
		end else if (a_busy_raw && rob_valid && rob_tag == a_raw[`TAG_W-1:0]) begin
			issue.a = rob_value;
			issue.a_busy = 1'b0;
		end
		if (b_busy_raw && result_valid && result_tag == b_raw[`TAG_W-1:0]) begin
			issue.b = result_value;
			issue.b_busy = 1'b0;
		end else if (b_busy_raw && rob_valid && rob_tag == b_raw[`TAG_W-1:0]) begin
			issue.b = rob_value;
			issue.b_busy = 1'b0;
		end
	end

	assign issue.valid = issue_valid;
	assign issue.tag = tag;

endmodule

`default_nettype wire

// File: logic/reservation_station.sv
`timescale 1ns/1ns
`default_nettype none

`include "rs_consts.svh"

module reservation_station
	import rs_pkg::*;
(
	input logic clk,
	input logic rst,
	rs_issue_if.dst issue,
	rs_dispatch_if.src disp,
	input logic result_valid,
	input logic rob_valid,
	input rob_tag_t result_tag,
	input rob_tag_t rob_tag,
	input word_t result_value,
	input word_t rob_value,
	input logic flush_valid,
	input rob_tag_t flush_front,
	input rob_tag_t flush_tag,
	output logic issue_ready,
	output rs_count_t free_count
);
	localparam int IDX_W = $clog2(`RS_DEPTH);

	// entry storage
	logic [`RS_DEPTH-1:0] valid_q;
	rob_tag_t tag_q [`RS_DEPTH];
	alu_op_e alu_op_q [`RS_DEPTH];
	cmp_op_e cmp_op_q [`RS_DEPTH];
	logic [`RS_DEPTH-1:0] use_cmp_q;
	word_t a_q [`RS_DEPTH];
	word_t b_q [`RS_DEPTH];
	logic [`RS_DEPTH-1:0] a_busy_q;
	logic [`RS_DEPTH-1:0] b_busy_q;

	logic [`RS_DEPTH-1:0] ready;
	logic [IDX_W-1:0] free_idx;
	logic [IDX_W-1:0] sel_idx;
	logic have_free;
	logic any_ready;
	logic issue_fire;
	logic sel_keep;

	// walk down so the lowest index wins both searches
	always_comb begin
		free_idx = '0;
		sel_idx = '0;
		have_free = 1'b0;
		any_ready = 1'b0;
		free_count = '0;
		for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
			ready[i] = valid_q[i] && !a_busy_q[i] && !b_busy_q[i];
			if (!valid_q[i]) begin
				free_idx = IDX_W'(i);
				have_free = 1'b1;
				free_count = free_count + rs_count_t'(1);
			end
			if (ready[i]) begin
				sel_idx = IDX_W'(i);
				any_ready = 1'b1;
			end
		end
	end

	// no issue in a flush cycle
	assign issue_ready = have_free && !flush_valid;
	assign issue_fire = issue.valid && issue_ready;

	// the selected entry is dropped if the flush removes it
	assign sel_keep = !flush_valid || tag_in_window(tag_q[sel_idx], flush_front, flush_tag);

	// entry valid flags and the dispatch valid
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
			disp.valid <= 1'b0;
		end else begin
			for (int i = 0; i < `RS_DEPTH; i++) begin
				if (flush_valid && !tag_in_window(tag_q[i], flush_front, flush_tag)) begin
					valid_q[i] <= 1'b0;
				end else if (any_ready && sel_idx == IDX_W'(i)) begin
					// freed as soon as it leaves
					valid_q[i] <= 1'b0;
				end else if (issue_fire && free_idx == IDX_W'(i)) begin
					valid_q[i] <= 1'b1;
				end
			end
			disp.valid <= any_ready && sel_keep;
		end
	end

	// dispatch register, one cycle between selection and the execute unit
	always_ff @(posedge clk) begin
		if (any_ready) begin
			disp.tag <= tag_q[sel_idx];
			disp.alu_op <= alu_op_q[sel_idx];
			disp.cmp_op <= cmp_op_q[sel_idx];
			disp.use_cmp <= use_cmp_q[sel_idx];
			disp.a <= a_q[sel_idx];
			disp.b <= b_q[sel_idx];
		end
	end

	// entry write and operand wakeup
	always_ff @(posedge clk) begin
		for (int i = 0; i < `RS_DEPTH; i++) begin
			if (issue_fire && free_idx == IDX_W'(i)) begin
				tag_q[i] <= issue.tag;
				alu_op_q[i] <= issue.alu_op;
				cmp_op_q[i] <= issue.cmp_op;
				use_cmp_q[i] <= issue.use_cmp;
				a_q[i] <= issue.a;
				b_q[i] <= issue.b;
				a_busy_q[i] <= issue.a_busy;
				b_busy_q[i] <= issue.b_busy;
			end else begin
				// own result bus first, rob forward otherwise
				if (a_busy_q[i] && result_valid && result_tag == a_q[i][`TAG_W-1:0]) begin
					a_q[i] <= result_value;
					a_busy_q[i] <= 1'b0;
				end else if (a_busy_q[i] && rob_valid && rob_tag == a_q[i][`TAG_W-1:0]) begin
					a_q[i] <= rob_value;
					a_busy_q[i] <= 1'b0;
				end
				if (b_busy_q[i] && result_valid && result_tag == b_q[i][`TAG_W-1:0]) begin
					b_q[i] <= result_value;
					b_busy_q[i] <= 1'b0;
				end else if (b_busy_q[i] && rob_valid && rob_tag == b_q[i][`TAG_W-1:0]) begin
					b_q[i] <= rob_value;
					b_busy_q[i] <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "rs_consts.svh"

module exec_unit
	import rs_pkg::*;
(
	input logic clk,
	input logic rst,
	rs_dispatch_if.dst disp,
	input logic flush_valid,
	input rob_tag_t flush_front,
	input rob_tag_t flush_tag,
	output logic result_valid,
	output rob_tag_t result_tag,
	output word_t result_value
);
	localparam int SHAMT_W = $clog2(`XLEN);

	// stage one, registered operation
	logic s1_valid;
	rob_tag_t s1_tag;
	alu_op_e s1_alu_op;
	cmp_op_e s1_cmp_op;
	logic s1_use_cmp;
	word_t s1_a;
	word_t s1_b;

	word_t alu_res;
	logic cmp_res;

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			// flush squashes whatever sits outside the window
			s1_valid <= disp.valid &&
				(!flush_valid || tag_in_window(disp.tag, flush_front, flush_tag));
			result_valid <= s1_valid &&
				(!flush_valid || tag_in_window(s1_tag, flush_front, flush_tag));
		end
	end

	always_ff @(posedge clk) begin
		s1_tag <= disp.tag;
		s1_alu_op <= disp.alu_op;
		s1_cmp_op <= disp.cmp_op;
		s1_use_cmp <= disp.use_cmp;
		s1_a <= disp.a;
		s1_b <= disp.b;
		// stage two, result straight onto the bus
		result_tag <= s1_tag;
		result_value <= s1_use_cmp ? word_t'(cmp_res) : alu_res;
	end

	always_comb begin
		case (s1_alu_op)
			alu_add: alu_res = s1_a + s1_b;
			alu_sll: alu_res = s1_a << s1_b[SHAMT_W-1:0];
			alu_sra: alu_res = word_t'($signed(s1_a) >>> s1_b[SHAMT_W-1:0]);
			alu_sub: alu_res = s1_a - s1_b;
			alu_xor: alu_res = s1_a ^ s1_b;
			alu_srl: alu_res = s1_a >> s1_b[SHAMT_W-1:0];
			alu_or: alu_res = s1_a | s1_b;
			default: alu_res = s1_a & s1_b;
		endcase
	end

	// slt and sltu arrive here as blt and bltu
	always_comb begin
		case (s1_cmp_op)
			cmp_beq: cmp_res = s1_a == s1_b;
			cmp_bne: cmp_res = s1_a != s1_b;
			cmp_blt: cmp_res = $signed(s1_a) < $signed(s1_b);
			cmp_bge: cmp_res = $signed(s1_a) >= $signed(s1_b);
			cmp_bltu: cmp_res = s1_a < s1_b;
			cmp_bgeu: cmp_res = s1_a >= s1_b;
			default: cmp_res = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/rs_exec_top.sv
`timescale 1ns/1ns
`default_nettype none

module rs_exec_top
	import rs_pkg::*;
(
	input logic clk,
	input logic rst,
	// renamed instruction from the rob
	input logic issue_valid,
	input rob_tag_t tag,
	input rv32_opcode_e opcode,
	input logic [2:0] funct3,
	input logic funct7_5,
	input word_t pc,
	input word_t imm,
	input word_t rs1_val,
	input word_t rs2_val,
	input logic rs1_busy,
	input logic rs2_busy,
	// rob forwarding bus
	input logic rob_valid,
	input rob_tag_t rob_tag,
	input word_t rob_value,
	input logic flush_valid,
	input rob_tag_t flush_front,
	input rob_tag_t flush_tag,
	output logic issue_ready,
	output rs_count_t free_count,
	output logic result_valid,
	output rob_tag_t result_tag,
	output word_t result_value
);
	rs_issue_if issue_bus ();
	rs_dispatch_if disp_bus ();

	issue_decode issue_decode_i (
		.issue_valid(issue_valid),
		.tag(tag),
		.opcode(opcode),
		.funct3(funct3),
		.funct7_5(funct7_5),
		.pc(pc),
		.imm(imm),
		.rs1_val(rs1_val),
		.rs2_val(rs2_val),
		.rs1_busy(rs1_busy),
		.rs2_busy(rs2_busy),
		.result_valid(result_valid),
		.rob_valid(rob_valid),
		.result_tag(result_tag),
		.rob_tag(rob_tag),
		.result_value(result_value),
		.rob_value(rob_value),
		.issue(issue_bus)
	);

	reservation_station reservation_station_i (
		.clk(clk),
		.rst(rst),
		.issue(issue_bus),
		.disp(disp_bus),
		.result_valid(result_valid),
		.rob_valid(rob_valid),
		.result_tag(result_tag),
		.rob_tag(rob_tag),
		.result_value(result_value),
		.rob_value(rob_value),
		.flush_valid(flush_valid),
		.flush_front(flush_front),
		.flush_tag(flush_tag),
		.issue_ready(issue_ready),
		.free_count(free_count)
	);

	// results loop back to the station and the decoder bypass
	exec_unit exec_unit_i (
		.clk(clk),
		.rst(rst),
		.disp(disp_bus),
		.flush_valid(flush_valid),
		.flush_front(flush_front),
		.flush_tag(flush_tag),
		.result_valid(result_valid),
		.result_tag(result_tag),
		.result_value(result_value)
	);

endmodule

`default_nettype wire

// File: sim/rs_exec_assertions.sv
`timescale 1ns/1ns
`default_nettype none

`include "rs_consts.svh"

module rs_exec_assertions
	import rs_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic disp_valid,
	input logic flush_valid,
	input logic result_valid,
	input rs_count_t free_count
);

	// dispatch register is cleared while reset is held
	no_disp_in_reset: assert property (@(posedge clk) rst |=> !disp_valid)
		else $error("dispatch valid during reset");

	// two pipeline stages between dispatch and the result bus
	disp_to_result: assert property (@(posedge clk) disable iff (rst)
		disp_valid && !flush_valid ##1 !flush_valid |=> result_valid)
		else $error("result missing two cycles after dispatch");

	// count can never pass the entry count
	count_in_range: assert property (@(posedge clk) disable iff (rst)
		free_count <= rs_count_t'(`RS_DEPTH))
		else $error("free count above station depth");

endmodule

`default_nettype wire

// File: sim/rs_exec_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rs_consts.svh"

module rs_exec_tb
	import rs_pkg::*;
();
	localparam int TIMEOUT = 200;

	typedef struct {
		rv32_opcode_e op;
		logic [2:0] f3;
		logic f7;
		word_t pc;
		word_t imm;
		word_t a;
		word_t b;
	} row_t;

	logic clk = 1'b0;
	logic rst;
	logic issue_valid;
	rob_tag_t tag;
	rv32_opcode_e opcode;
	logic [2:0] funct3;
	logic funct7_5;
	word_t pc, imm, rs1_val, rs2_val;
	logic rs1_busy, rs2_busy;
	logic rob_valid;
	rob_tag_t rob_tag;
	word_t rob_value;
	logic flush_valid;
	rob_tag_t flush_front, flush_tag;
	logic issue_ready;
	rs_count_t free_count;
	logic result_valid;
	rob_tag_t result_tag;
	word_t result_value;

	// scoreboard indexed by tag
	logic pending [`ROB_DEPTH];
	word_t exp_val [`ROB_DEPTH];
	int outstanding = 0;
	row_t tbl [$];
	logic [31:0] seed = 32'h8a49;

	rs_exec_top rs_exec_top_i (.*);

	bind reservation_station rs_exec_assertions rs_chk_i (.clk(clk), .rst(rst),
		.disp_valid(disp.valid), .flush_valid(flush_valid),
		.result_valid(result_valid), .free_count(free_count));

	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// result rules written out per opcode
	function automatic word_t ref_result(row_t r);
		word_t b2;
		b2 = (r.op == op_imm) ? r.imm : r.b;
		case (r.op)
			op_lui: return r.imm;
			op_auipc, op_jal: return r.pc + r.imm;
			op_jalr: return r.a + r.imm;
			op_br: begin
				case (r.f3)
					3'b000: return word_t'(r.a == r.b);
					3'b001: return word_t'(r.a != r.b);
					3'b100: return word_t'($signed(r.a) < $signed(r.b));
					3'b101: return word_t'($signed(r.a) >= $signed(r.b));
					3'b110: return word_t'(r.a < r.b);
					default: return word_t'(r.a >= r.b);
				endcase
			end
			default: begin
				case (r.f3)
					3'b000: return (r.op == op_reg && r.f7) ? r.a - b2 : r.a + b2;
					3'b001: return r.a << b2[4:0];
					3'b010: return word_t'($signed(r.a) < $signed(b2));
					3'b011: return word_t'(r.a < b2);
					3'b100: return r.a ^ b2;
					3'b101: return r.f7 ? word_t'($signed(r.a) >>> b2[4:0]) : r.a >> b2[4:0];
					3'b110: return r.a | b2;
					default: return r.a & b2;
				endcase
			end
		endcase
	endfunction

	task automatic add_row(rv32_opcode_e op, logic [2:0] f3, logic f7);
		row_t r;
		r.op = op;
		r.f3 = f3;
		r.f7 = f7;
		r.pc = lcg_next();
		r.imm = lcg_next();
		r.a = lcg_next();
		r.b = lcg_next();
		tbl.push_back(r);
	endtask

	task automatic timeout_fail(string what);
		$display("Timeout while waiting for %s", what);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp) begin
			$display("** Error %s: got %h expected %h", name, got, exp);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic check_tag(string name, rob_tag_t got, rob_tag_t exp);
		if (got !== exp) begin
			$display("** Error %s: got %h expected %h", name, got, exp);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic check_count(string name, rs_count_t got, rs_count_t exp);
		if (got !== exp) begin
			$display("** Error %s: got %h expected %h", name, got, exp);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	// results sampled away from the rising edge
	always @(negedge clk) begin
		if (!rst && result_valid) begin
			if (pending[result_tag] !== 1'b1) begin
				$display("Unexpected result for tag %h", result_tag);
				$display("Errors found");
				$fatal(1);
			end else begin
				check_word("result_value", result_value, exp_val[result_tag]);
				pending[result_tag] = 1'b0;
				outstanding--;
			end
		end
	end

	task automatic expect_result(rob_tag_t t, word_t v);
		exp_val[t] = v;
		pending[t] = 1'b1;
		outstanding++;
	endtask

	// called one ns after an edge, returns at the same phase
	task automatic issue_instr(rob_tag_t t, row_t r, logic a_busy, logic b_busy);
		int waited;
		waited = 0;
		tag = t;
		opcode = r.op;
		funct3 = r.f3;
		funct7_5 = r.f7;
		pc = r.pc;
		imm = r.imm;
		rs1_val = r.a;
		rs2_val = r.b;
		rs1_busy = a_busy;
		rs2_busy = b_busy;
		issue_valid = 1'b1;
		#1;
		while (!issue_ready) begin
			if (waited >= TIMEOUT)
				timeout_fail("issue_ready");
			@(posedge clk);
			#2;
			waited++;
		end
		@(posedge clk);
		#1;
		issue_valid = 1'b0;
	endtask

	// returns one ns into the cycle in which tag t is on the result bus
	task automatic wait_broadcast(rob_tag_t t);
		int waited;
		waited = 0;
		while (!(result_valid && result_tag == t)) begin
			if (waited >= TIMEOUT)
				timeout_fail("a result broadcast");
			@(posedge clk);
			#1;
			waited++;
		end
	endtask

	task automatic wait_tag_free(rob_tag_t t);
		int waited;
		waited = 0;
		while (pending[t]) begin
			if (waited >= TIMEOUT)
				timeout_fail("a free tag");
			@(posedge clk);
			#1;
			waited++;
		end
	endtask

	task automatic wait_done();
		int waited;
		waited = 0;
		while (outstanding != 0) begin
			if (waited >= TIMEOUT)
				timeout_fail("outstanding results");
			@(posedge clk);
			#1;
			waited++;
		end
	endtask

	task automatic pulse_rob(rob_tag_t t, word_t v);
		rob_valid = 1'b1;
		rob_tag = t;
		rob_value = v;
		@(posedge clk);
		#1;
		rob_valid = 1'b0;
	endtask

	initial begin
		row_t r;
		word_t fwd;
		word_t v;
		int waited;
		for (int i = 0; i < `ROB_DEPTH; i++)
			pending[i] = 1'b0;
		rst = 1'b1;
		issue_valid = 1'b0;
		tag = '0;
		opcode = op_imm;
		funct3 = '0;
		funct7_5 = 1'b0;
		pc = '0;
		imm = '0;
		rs1_val = '0;
		rs2_val = '0;
		rs1_busy = 1'b0;
		rs2_busy = 1'b0;
		rob_valid = 1'b0;
		rob_tag = '0;
		rob_value = '0;
		flush_valid = 1'b0;
		flush_front = '0;
		flush_tag = '0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		#1;
		// idle state after reset
		check_word("result_valid", word_t'(result_valid), '0);
		check_word("issue_ready", word_t'(issue_ready), 32'h1);
		check_count("free_count", free_count, rs_count_t'(`RS_DEPTH));

		// every funct3 of the register and immediate forms, branches, upper and jumps
		for (int f = 0; f < 8; f++)
			add_row(op_reg, 3'(f), 1'b0);
		add_row(op_reg, 3'b000, 1'b1);
		add_row(op_reg, 3'b101, 1'b1);
		for (int f = 0; f < 8; f++)
			add_row(op_imm, 3'(f), f == 5);
		add_row(op_br, 3'b000, 1'b0);
		tbl[tbl.size()-1].b = tbl[tbl.size()-1].a;
		add_row(op_br, 3'b001, 1'b0);
		add_row(op_br, 3'b100, 1'b0);
		add_row(op_br, 3'b101, 1'b0);
		add_row(op_br, 3'b110, 1'b0);
		add_row(op_br, 3'b111, 1'b0);
		tbl[tbl.size()-1].b = tbl[tbl.size()-1].a;
		add_row(op_lui, 3'b000, 1'b0);
		add_row(op_auipc, 3'b000, 1'b0);
		add_row(op_jal, 3'b000, 1'b0);
		add_row(op_jalr, 3'b000, 1'b0);
		@(posedge clk);
		#1;
		for (int k = 0; k < tbl.size(); k++) begin
			wait_tag_free(rob_tag_t'(k));
			expect_result(rob_tag_t'(k), ref_result(tbl[k]));
			issue_instr(rob_tag_t'(k), tbl[k], 1'b0, 1'b0);
		end
		wait_done();

		// operand forwarded later by the rob bus
		r = '{op_imm, 3'b000, 1'b0, '0, lcg_next(), 32'd11, '0};
		issue_instr(4'd10, r, 1'b1, 1'b0);
		repeat (6) @(posedge clk);
		#1;
		fwd = lcg_next();
		expect_result(4'd10, fwd + r.imm);
		pulse_rob(4'd11, fwd);
		waited = 0;
		while (!result_valid) begin
			if (waited >= TIMEOUT)
				timeout_fail("the forwarded result");
			@(posedge clk);
			#1;
			waited++;
		end
		check_tag("result_tag", result_tag, 4'd10);
		wait_done();

		// dependency chain through result bus wakeup and the issue bypass
		v = lcg_next();
		for (int k = 0; k < 6; k++) begin
			r = '{op_imm, 3'b000, 1'b0, '0, word_t'(k * 3 + 1), v, '0};
			if (k > 0)
				r.a = word_t'(k - 1);
			v = ((k > 0) ? v : r.a) + r.imm;
			expect_result(rob_tag_t'(k), v);
			// even links issue while the producer is on the bus, only the bypass sees it
			if (k > 0 && k % 2 == 0)
				wait_broadcast(rob_tag_t'(k - 1));
			issue_instr(rob_tag_t'(k), r, k > 0, 1'b0);
		end
		wait_done();

		// fill the station with entries waiting on tag 15
		for (int k = 0; k < `RS_DEPTH; k++) begin
			r = '{op_imm, 3'b000, 1'b0, '0, word_t'(k + 100), 32'd15, '0};
			issue_instr(rob_tag_t'(k), r, 1'b1, 1'b0);
		end
		#1;
		check_count("free_count", free_count, '0);
		check_word("issue_ready", word_t'(issue_ready), '0);
		r = '{op_reg, 3'b110, 1'b0, '0, '0, lcg_next(), lcg_next()};
		expect_result(4'd8, ref_result(r));
		tag = 4'd8;
		opcode = r.op;
		funct3 = r.f3;
		funct7_5 = r.f7;
		rs1_val = r.a;
		rs2_val = r.b;
		rs1_busy = 1'b0;
		issue_valid = 1'b1;
		repeat (3) begin
			@(posedge clk);
			#2;
			check_word("issue_ready", word_t'(issue_ready), '0);
		end
		@(posedge clk);
		#1;
		fwd = lcg_next();
		for (int k = 0; k < `RS_DEPTH; k++)
			expect_result(rob_tag_t'(k), fwd + word_t'(k + 100));
		pulse_rob(4'd15, fwd);
		issue_instr(4'd8, r, 1'b0, 1'b0);
		wait_done();

		// flush window 4..5 keeps two of four waiting entries
		for (int k = 4; k < 8; k++) begin
			r = '{op_imm, 3'b000, 1'b0, '0, word_t'(k), 32'd12, '0};
			issue_instr(rob_tag_t'(k), r, 1'b1, 1'b0);
		end
		flush_front = 4'd4;
		flush_tag = 4'd6;
		flush_valid = 1'b1;
		@(posedge clk);
		#1;
		flush_valid = 1'b0;
		check_count("free_count", free_count, rs_count_t'(`RS_DEPTH - 2));
		fwd = lcg_next();
		expect_result(4'd4, fwd + 32'd4);
		expect_result(4'd5, fwd + 32'd5);
		pulse_rob(4'd12, fwd);
		wait_done();
		repeat (8) @(posedge clk);
		#1;
		check_count("free_count", free_count, rs_count_t'(`RS_DEPTH));

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+logic
logic/rs_pkg.sv
logic/rs_if.sv
logic/issue_decode.sv
logic/reservation_station.sv
logic/exec_unit.sv
logic/rs_exec_top.sv
sim/rs_exec_assertions.sv
sim/rs_exec_tb.sv
